/* tb/williams_io_testdata.txt */
// game settings sg_state cont1_key cont2_key cont1_joy ja jb btn sw flags
// flags is {blitter_sc2, sinistar}, all values hex
0 0 0 C011 0 00000000 7E 7E 5 0 0
0 0 0 0200 0 0000F010 A9 A9 0 1 0
1 0 0 4114 8008 00000000 FA FD 5 2 0
2 0 1 0024 0 00000000 7D 7D 0 0 0
2 1 0 8140 0 00000000 EB EB 2 0 0
3 0 0 000A 4000 00000000 F5 F5 1 0 0
4 0 0 0041 8082 00000000 EE BD 2 0 2
5 0 0 0005 0 00000000 F7 F7 0 0 1
5 0 0 0008 0 000050F0 74 74 0 0 1
5 0 0 4008 0 00001080 77 77 1 0 1
6 0 0 C008 8000 00000000 F2 F2 1 0 0
7 0 0 0022 8011 00000000 DD EE 2 0 0

/* compile.f */
rtl/williams_pkg.sv
rtl/bridge_config_regs.sv
rtl/control_sync.sv
rtl/stick_quantizer.sv
rtl/control_mapper.sv
rtl/blank_timing.sv
rtl/video_formatter.sv
rtl/williams_io_top.sv
tb/williams_io_props.sv
tb/tb_williams_io.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
TOP        ?= tb_williams_io
RTL_TOP    ?= williams_io_top
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_williams_io.sv */
// Williams I/O glue testbench
// file-driven control mapper checks, random and regular video checks

`timescale 1ns/1ns
`default_nettype none

module tb_williams_io;
    import williams_pkg::*;

    localparam int NROWS = 12;
    localparam int NCOLS = 11;
    localparam int LIMIT = 20000;

    logic        clk_74a;
    logic        rst_n;
    logic        bridge_wr;
    logic [31:0] bridge_addr;
    logic [31:0] bridge_wr_data;
    logic [15:0] cont1_key;
    logic [15:0] cont2_key;
    logic [31:0] cont1_joy;
    logic        sg_state;
    logic        hs_core;
    logic        vs_core;
    logic [2:0]  r;
    logic [2:0]  g;
    logic [1:0]  b;
    logic [7:0]  ja;
    logic [7:0]  jb;
    logic [2:0]  btn;
    logic [7:0]  sw;
    logic        blitter_sc2;
    logic        sinistar;
    logic [23:0] video_rgb;
    logic        video_de;
    logic        video_hs;
    logic        video_vs;

    logic [31:0] tdata [0:NROWS*NCOLS-1];
    integer      seed;
    integer      cycles;
    logic        video_on;
    logic        cur_landscape;

    // reference model state for the video path
    integer      m_pcnt;
    integer      m_lcnt;
    logic        m_hs_prev;
    logic        m_vs_prev;
    logic        m_vs_line;
    logic        m_hblank;
    logic        m_vblank;
    logic        exp_de;
    logic        exp_hs;
    logic        exp_vs;
    logic [23:0] exp_rgb;

    williams_io_top #(.SYNC_STAGES(3), .CNT_W(11)) i_williams_io_top (
        .clk_74a(clk_74a), .rst_n(rst_n), .bridge_wr(bridge_wr),
        .bridge_addr(bridge_addr), .bridge_wr_data(bridge_wr_data),
        .cont1_key(cont1_key), .cont2_key(cont2_key), .cont1_joy(cont1_joy),
        .sg_state(sg_state), .hs_core(hs_core), .vs_core(vs_core),
        .r(r), .g(g), .b(b), .ja(ja), .jb(jb), .btn(btn), .sw(sw),
        .blitter_sc2(blitter_sc2), .sinistar(sinistar), .video_rgb(video_rgb),
        .video_de(video_de), .video_hs(video_hs), .video_vs(video_vs)
    );

    initial begin
        clk_74a = 1'b0;
        forever #10 clk_74a = ~clk_74a;
    end

    //////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        bridge_wr      = 1'b1;
        bridge_addr    = addr;
        bridge_wr_data = data;
        @(negedge clk_74a);
        bridge_wr      = 1'b0;
    endtask

    task automatic select_game(input logic [2:0] gid);
        bridge_write(ADDR_GAME_ID, 32'(gid));
        cur_landscape = !(gid == 3'd5 || gid == 3'd6);
    endtask

    // 3-bit channel to 8 bits by repeating the pattern
    function automatic logic [7:0] widen3(input logic [2:0] v);
        logic [8:0] t;
        t = 9'(v) * 9'd73;
        return t[8:1];
    endfunction

    function automatic logic [7:0] widen2(input logic [1:0] v);
        return 8'(v) * 8'd85;
    endfunction

    //////////////////////////////////////////////////////////////
    // video reference model and checks
    //////////////////////////////////////////////////////////////

    always @(posedge clk_74a) begin
        if (!rst_n) begin
            m_pcnt    <= 0;
            m_lcnt    <= 0;
            m_hs_prev <= 1'b0;
            m_vs_prev <= 1'b0;
            m_vs_line <= 1'b0;
            m_hblank  <= 1'b0;
            m_vblank  <= 1'b0;
            exp_de    <= 1'b0;
            exp_hs    <= 1'b0;
            exp_vs    <= 1'b0;
        end else begin
            m_hs_prev <= hs_core;
            m_vs_prev <= vs_core;
            if (hs_core && !m_hs_prev) begin
                m_pcnt    <= 0;
                m_vs_line <= vs_core;
                if (vs_core && !m_vs_line)
                    m_lcnt <= 0;
                else if (m_lcnt < 2047)
                    m_lcnt <= m_lcnt + 1;
            end else if (m_pcnt < 2047) begin
                m_pcnt <= m_pcnt + 1;
            end
            if (m_pcnt / 2 == HBLANK_START)
                m_hblank <= 1'b1;
            else if (m_pcnt / 2 == HBLANK_END)
                m_hblank <= 1'b0;
            if (m_lcnt == VBLANK_START)
                m_vblank <= 1'b1;
            else if (m_lcnt == VBLANK_END)
                m_vblank <= 1'b0;
            exp_de <= !(m_hblank || m_vblank);
            exp_hs <= hs_core && !m_hs_prev;
            exp_vs <= vs_core && !m_vs_prev;
        end
        if (!(m_hblank || m_vblank))
            exp_rgb <= {widen3(r), widen3(g), widen2(b)};
        else
            exp_rgb <= cur_landscape ? 24'h0 : PORTRAIT_BG;
    end

    always @(negedge clk_74a) begin
        if (video_on) begin
            check_val("video_de", 32'(exp_de), 32'(video_de));
            check_val("video_hs", 32'(exp_hs), 32'(video_hs));
            check_val("video_vs", 32'(exp_vs), 32'(video_vs));
            check_val("video_rgb", 32'(exp_rgb), 32'(video_rgb));
        end
    end

    // bound assertions count their failures
    always @(negedge clk_74a) begin
        if (i_williams_io_top.i_williams_io_props.fail_count != 0) begin
            $display("bound assertion failed at time %0t", $time);
            $display("TEST FAILED");
            $fatal(1, "assertion failure");
        end
    end

    always @(posedge clk_74a) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: tests did not finish");
            $display("TEST FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    //////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////

    initial begin
        integer row;
        integer base;
        integer line;
        integer c;
        logic [31:0] rnd;

        seed           = 32'hb400cf68;
        cycles         = 0;
        video_on       = 1'b0;
        cur_landscape  = 1'b1;
        rst_n          = 1'b0;
        bridge_wr      = 1'b0;
        bridge_addr    = '0;
        bridge_wr_data = '0;
        cont1_key      = '0;
        cont2_key      = '0;
        cont1_joy      = '0;
        sg_state       = 1'b0;
        hs_core        = 1'b0;
        vs_core        = 1'b0;
        r              = '0;
        g              = '0;
        b              = '0;
        $readmemh("tb/williams_io_testdata.txt", tdata);

        repeat (10) @(negedge clk_74a);
        check_val("video_de", 32'h0, 32'(video_de));
        check_val("video_hs", 32'h0, 32'(video_hs));
        check_val("video_vs", 32'h0, 32'(video_vs));
        rst_n = 1'b1;
        repeat (2) @(negedge clk_74a);
        check_val("ja", 32'hff, 32'(ja));
        check_val("jb", 32'hff, 32'(jb));
        check_val("btn", 32'h0, 32'(btn));
        check_val("sw", 32'h0, 32'(sw));
        check_val("blitter_sc2", 32'h0, 32'(blitter_sc2));
        check_val("sinistar", 32'h0, 32'(sinistar));
        check_val("landscape", 32'h1, 32'(i_williams_io_top.landscape));
        check_val("game_id", 32'h0, 32'(i_williams_io_top.game_id));
        check_val("original_controls", 32'h0, 32'(i_williams_io_top.original_controls));

        // one row per game setup
        for (row = 0; row < NROWS; row++) begin
            base = row * NCOLS;
            select_game(tdata[base][2:0]);
            sg_state  = tdata[base+2][0];
            cont1_key = tdata[base+3][15:0];
            cont2_key = tdata[base+4][15:0];
            cont1_joy = tdata[base+5];
            bridge_write(ADDR_SETTINGS, tdata[base+1]);
            repeat (5) @(negedge clk_74a);
            check_val("ja", tdata[base+6], 32'(ja));
            check_val("jb", tdata[base+7], 32'(jb));
            check_val("btn", tdata[base+8], 32'(btn));
            check_val("sw", tdata[base+9], 32'(sw));
            check_val("blitter_sc2", 32'(tdata[base+10][1]), 32'(blitter_sc2));
            check_val("sinistar", 32'(tdata[base+10][0]), 32'(sinistar));
        end

        // random video in a portrait game
        select_game(3'd5);
        repeat (4) @(negedge clk_74a);
        video_on = 1'b1;
        for (c = 0; c < 2000; c++) begin
            rnd     = $random(seed);
            r       = rnd[2:0];
            g       = rnd[5:3];
            b       = rnd[7:6];
            hs_core = rnd[8] ? ~hs_core : hs_core;
            // vs held low until the line count has run past the vblank start
            vs_core = (c >= 1200 && rnd[15:11] == 5'd0) ? ~vs_core : vs_core;
            @(negedge clk_74a);
        end

        // regular lines in a landscape game
        video_on = 1'b0;
        hs_core  = 1'b0;
        vs_core  = 1'b0;
        select_game(3'd0);
        repeat (4) @(negedge clk_74a);
        video_on = 1'b1;
        for (line = 0; line < 16; line++) begin
            for (c = 0; c < 800; c++) begin
                rnd     = $random(seed);
                r       = rnd[2:0];
                g       = rnd[5:3];
                b       = rnd[7:6];
                hs_core = c < 64;
                vs_core = line >= 4 && line < 6;
                @(negedge clk_74a);
            end
        end
        video_on = 1'b0;

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/williams_io_props.sv */
// Williams I/O glue properties
// pulse shape, data enable against blanking and reset values

`timescale 1ns/1ns
`default_nettype none

module williams_io_props (
    input wire       clk_74a,
    input wire       rst_n,
    input wire       video_hs,
    input wire       video_vs,
    input wire       video_de,
    input wire       hblank,
    input wire       vblank,
    input wire [7:0] ja,
    input wire [2:0] btn
);

    // number of assertion failures so far
    int fail_count = 0;

    hs_single: assert property (@(posedge clk_74a) disable iff (!rst_n)
        video_hs |=> !video_hs) else begin
        fail_count++;
        $error("video_hs high two cycles");
    end

    vs_single: assert property (@(posedge clk_74a) disable iff (!rst_n)
        video_vs |=> !video_vs) else begin
        fail_count++;
        $error("video_vs high two cycles");
    end

    // de follows the blanking one cycle later
    de_unblanked: assert property (@(posedge clk_74a) disable iff (!rst_n)
        video_de |-> $past(!(hblank || vblank))) else begin
        fail_count++;
        $error("video_de during blanking");
    end

    reset_vals: assert property (@(posedge clk_74a)
        $past(!rst_n) |-> (ja == 8'hff && btn == 3'b000)) else begin
        fail_count++;
        $error("bad reset values");
    end

endmodule

bind williams_io_top williams_io_props i_williams_io_props (
    .clk_74a(clk_74a), .rst_n(rst_n), .video_hs(video_hs), .video_vs(video_vs),
    .video_de(video_de), .hblank(hblank), .vblank(vblank), .ja(ja), .btn(btn)
);

`default_nettype wire

/* rtl/williams_io_top.sv */
// Williams I/O glue top level
// control path sync -> quantise -> map, video path blank timing -> format

`timescale 1ns/1ns
`default_nettype none

module williams_io_top #(
    parameter int SYNC_STAGES = 3,
    parameter int CNT_W       = 11
) (
    input  wire                            clk_74a,
    input  wire                            rst_n,
    input  wire                            bridge_wr,
    input  wire  [31:0]                    bridge_addr,
    input  wire  [31:0]                    bridge_wr_data,
    input  wire  [williams_pkg::KEY_W-1:0] cont1_key,
    input  wire  [williams_pkg::KEY_W-1:0] cont2_key,
    input  wire  [williams_pkg::JOY_W-1:0] cont1_joy,
    input  wire                            sg_state,
    input  wire                            hs_core,
    input  wire                            vs_core,
    input  wire  [2:0]                     r,
    input  wire  [2:0]                     g,
    input  wire  [1:0]                     b,
    output logic [7:0]                     ja,
    output logic [7:0]                     jb,
    output logic [2:0]                     btn,
    output logic [7:0]                     sw,
    output logic                           blitter_sc2,
    output logic                           sinistar,
    output logic [23:0]                    video_rgb,
    output logic                           video_de,
    output logic                           video_hs,
    output logic                           video_vs
);
    import williams_pkg::*;

    game_id_t         game_id;
    logic             original_controls;
    logic [KEY_W-1:0] key1_s;
    logic [KEY_W-1:0] key2_s;
    logic [JOY_W-1:0] joy1_s;
    logic [7:0]       stick_dir;
    logic             stick_present;
    logic [3:0]       quant_x;
    logic [3:0]       quant_y;
    logic             landscape;
    logic             hblank;
    logic             vblank;

    bridge_config_regs i_bridge_config_regs (
        .clk_74a(clk_74a), .rst_n(rst_n), .bridge_wr(bridge_wr),
        .bridge_addr(bridge_addr), .bridge_wr_data(bridge_wr_data),
        .game_id(game_id), .original_controls(original_controls)
    );

    //////////////////////////////////////////////////////////////
    // control path
    //////////////////////////////////////////////////////////////

    control_sync #(.SYNC_STAGES(SYNC_STAGES)) i_control_sync (
        .clk_74a(clk_74a), .rst_n(rst_n),
        .cont1_key(cont1_key), .cont2_key(cont2_key), .cont1_joy(cont1_joy),
        .key1_s(key1_s), .key2_s(key2_s), .joy1_s(joy1_s)
    );

    stick_quantizer i_stick_quantizer (
        .joy1_s(joy1_s), .stick_dir(stick_dir), .stick_present(stick_present),
        .quant_x(quant_x), .quant_y(quant_y)
    );

    control_mapper i_control_mapper (
        .clk_74a(clk_74a), .rst_n(rst_n), .game_id(game_id),
        .original_controls(original_controls), .sg_state(sg_state),
        .key1_s(key1_s), .key2_s(key2_s), .stick_dir(stick_dir),
        .stick_present(stick_present), .quant_x(quant_x), .quant_y(quant_y),
        .ja(ja), .jb(jb), .btn(btn), .sw(sw), .blitter_sc2(blitter_sc2),
        .sinistar(sinistar), .landscape(landscape)
    );

    //////////////////////////////////////////////////////////////
    // video path
    //////////////////////////////////////////////////////////////

    blank_timing #(.CNT_W(CNT_W)) i_blank_timing (
        .clk_74a(clk_74a), .rst_n(rst_n), .hs_core(hs_core), .vs_core(vs_core),
        .hblank(hblank), .vblank(vblank)
    );

    video_formatter i_video_formatter (
        .clk_74a(clk_74a), .rst_n(rst_n), .hblank(hblank), .vblank(vblank),
        .landscape(landscape), .hs_core(hs_core), .vs_core(vs_core),
        .r(r), .g(g), .b(b), .video_rgb(video_rgb), .video_de(video_de),
        .video_hs(video_hs), .video_vs(video_vs)
    );

endmodule

`default_nettype wire

/* rtl/video_formatter.sv */
// Video formatter
// 3-3-2 colour to RGB888, data enable and sync edge pulses

`timescale 1ns/1ns
`default_nettype none

module video_formatter (
    input  wire         clk_74a,
    input  wire         rst_n,
    input  wire         hblank,
    input  wire         vblank,
    input  wire         landscape,
    input  wire         hs_core,
    input  wire         vs_core,
    input  wire  [2:0]  r,
    input  wire  [2:0]  g,
    input  wire  [1:0]  b,
    output logic [23:0] video_rgb,
    output logic        video_de,
    output logic        video_hs,
    output logic        video_vs
);
    import williams_pkg::*;

    logic hs_prev;
    logic vs_prev;

    wire active = ~(hblank | vblank);

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            video_de <= 1'b0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
            hs_prev  <= 1'b0;
            vs_prev  <= 1'b0;
        end else begin
            video_de <= active;
            video_hs <= hs_core & ~hs_prev;
            video_vs <= vs_core & ~vs_prev;
            hs_prev  <= hs_core;
            vs_prev  <= vs_core;
        end
    end

    // channel bits repeated to fill each byte
    always_ff @(posedge clk_74a) begin
        if (active)
            video_rgb <= {r, r, r[2:1], g, g, g[2:1], {4{b}}};
        else
            video_rgb <= landscape ? 24'h000000 : PORTRAIT_BG;
    end

endmodule

`default_nettype wire

/* rtl/blank_timing.sv */
// Blank timing
// counts pixels and lines from core sync to derive hblank and vblank

`timescale 1ns/1ns
`default_nettype none

module blank_timing #(
    parameter int CNT_W = 11
) (
    input  wire  clk_74a,
    input  wire  rst_n,
    input  wire  hs_core,
    input  wire  vs_core,
    output logic hblank,
    output logic vblank
);
    import williams_pkg::*;

    logic [CNT_W-1:0] pcnt;
    logic [CNT_W-1:0] lcnt;
    logic             hs_prev;
    // vs as sampled at the previous line start
    logic             vs_line;

    wire hs_rise = hs_core & ~hs_prev;

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            pcnt    <= '0;
            lcnt    <= '0;
            hs_prev <= 1'b0;
            vs_line <= 1'b0;
            hblank  <= 1'b0;
            vblank  <= 1'b0;
        end else begin
            hs_prev <= hs_core;
            if (!(&pcnt))
                pcnt <= pcnt + 1'b1;
            if (hs_rise) begin
                pcnt    <= '0;
                vs_line <= vs_core;
                if (!(&lcnt))
                    lcnt <= lcnt + 1'b1;
                // new frame
                if (vs_core && !vs_line)
                    lcnt <= '0;
            end

            if (pcnt[CNT_W-1:1] == (CNT_W-1)'(HBLANK_START))
                hblank <= 1'b1;
            if (pcnt[CNT_W-1:1] == (CNT_W-1)'(HBLANK_END))
                hblank <= 1'b0;
            if (lcnt == CNT_W'(VBLANK_START))
                vblank <= 1'b1;
            if (lcnt == CNT_W'(VBLANK_END))
                vblank <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/control_mapper.sv */
// Per-game controller mapper
// builds registered active-low JA/JB, BTN, SW and game flags

`timescale 1ns/1ns
`default_nettype none

module control_mapper (
    input  wire                            clk_74a,
    input  wire                            rst_n,
    input  williams_pkg::game_id_t         game_id,
    input  wire                            original_controls,
    input  wire                            sg_state,
    input  wire  [williams_pkg::KEY_W-1:0] key1_s,
    input  wire  [williams_pkg::KEY_W-1:0] key2_s,
    input  wire  [7:0]                     stick_dir,
    input  wire                            stick_present,
    input  wire  [3:0]                     quant_x,
    input  wire  [3:0]                     quant_y,
    output logic [7:0]                     ja,
    output logic [7:0]                     jb,
    output logic [2:0]                     btn,
    output logic [7:0]                     sw,
    output logic                           blitter_sc2,
    output logic                           sinistar,
    output logic                           landscape
);
    import williams_pkg::*;

    //////////////////////////////////////////////////////////////
    // pad key decode
    //////////////////////////////////////////////////////////////

    wire up1    = key1_s[0];
    wire down1  = key1_s[1];
    wire left1  = key1_s[2];
    wire right1 = key1_s[3];
    wire a1     = key1_s[4];
    wire b1     = key1_s[5];
    wire x1     = key1_s[6];
    wire y1     = key1_s[7];
    wire l1     = key1_s[8];
    wire r1     = key1_s[9];
    wire coin1  = key1_s[14];
    wire start1 = key1_s[15];

    wire up2    = key2_s[0];
    wire down2  = key2_s[1];
    wire left2  = key2_s[2];
    wire right2 = key2_s[3];
    wire a2     = key2_s[4];
    wire b2     = key2_s[5];
    wire x2     = key2_s[6];
    wire y2     = key2_s[7];
    wire coin2  = key2_s[14];
    wire start2 = key2_s[15];

    // twin-stick layout in stick_dir bit order
    wire [7:0] twin1 = {a1, y1, b1, x1, right1, left1, down1, up1};
    wire [7:0] twin2 = {a2, y2, b2, x2, right2, left2, down2, up2};

    // sinistar takes a 4-bit position per axis
    wire [3:0] dig_x = left1 ? 4'd0 : (right1 ? 4'd8 : QUANT_CENTRE);
    wire [3:0] dig_y = down1 ? 4'd0 : (up1 ? 4'd8 : QUANT_CENTRE);
    wire [3:0] sin_x = (stick_present && quant_x != QUANT_CENTRE) ? quant_x : dig_x;
    wire [3:0] sin_y = (stick_present && quant_y != QUANT_CENTRE) ? quant_y : dig_y;

    wire sg_thrust  = original_controls ? l1 : (sg_state ? right1 : left1);
    wire sg_reverse = original_controls ? r1 : (sg_state ? left1 : right1);

    //////////////////////////////////////////////////////////////
    // per-game layout in active-high form
    //////////////////////////////////////////////////////////////

    logic [7:0] ja_d;
    logic [7:0] jb_d;
    logic [2:0] btn_d;
    logic       blitter_d;
    logic       sinistar_d;
    logic       landscape_d;

    always_comb begin
        ja_d        = '0;
        jb_d        = '0;
        btn_d       = '0;
        blitter_d   = 1'b0;
        sinistar_d  = 1'b0;
        landscape_d = 1'b1;
        case (game_id)
            GAME_ROBOTRON: begin
                btn_d = {start1, start2, coin1 | coin2};
                ja_d  = stick_present ? (stick_dir | twin1) : twin1;
                jb_d  = ja_d;
            end
            GAME_JOUST: begin
                btn_d = {start2, start1, coin1 | coin2};
                ja_d  = {5'b0, a1, right1, left1};
                jb_d  = {5'b0, a2, right2, left2};
            end
            GAME_STARGATE: begin
                btn_d = {start2, start1, coin1};
                ja_d  = {b1, up1, down1, sg_thrust, y1, x1, sg_reverse, a1};
                jb_d  = ja_d;
            end
            GAME_BUBBLES: begin
                btn_d = {start2, start1, coin1 | coin2};
                ja_d  = {4'b0, right1, left1, down1, up1};
                jb_d  = ja_d;
            end
            GAME_SPLAT: begin
                blitter_d = 1'b1;
                btn_d     = {start1, start2, coin1 | coin2};
                ja_d      = twin1;
                jb_d      = twin2;
            end
            GAME_SINISTAR: begin
                sinistar_d  = 1'b1;
                landscape_d = 1'b0;
                btn_d       = {start1, start2, coin1};
                ja_d        = {sin_x, sin_y};
                jb_d        = ja_d;
            end
            GAME_PLAYBALL: begin
                landscape_d = 1'b0;
                btn_d       = {2'b0, coin1};
                ja_d        = {4'b0, start2, right1, left1, start1};
                jb_d        = ja_d;
            end
            GAME_ALIENARENA: begin
                btn_d = {start1, start2, coin1};
                ja_d  = {2'b0, b1, a1, right1, left1, down1, up1};
                jb_d  = {2'b0, b2, a2, right2, left2, down2, up2};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            ja          <= 8'hff;
            jb          <= 8'hff;
            btn         <= '0;
            sw          <= '0;
            blitter_sc2 <= 1'b0;
            sinistar    <= 1'b0;
            landscape   <= 1'b1;
        end else begin
            ja          <= ~ja_d;
            jb          <= ~jb_d;
            btn         <= btn_d;
            // advance is coin with L1, auto-up is R1
            sw          <= {6'b0, coin1 & l1, r1};
            blitter_sc2 <= blitter_d;
            sinistar    <= sinistar_d;
            landscape   <= landscape_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/stick_quantizer.sv */
// Analog stick quantiser
// direction flags for both sticks, eight-way positions for the left one

`timescale 1ns/1ns
`default_nettype none

module stick_quantizer (
    input  wire  [williams_pkg::JOY_W-1:0] joy1_s,
    output logic [7:0]                     stick_dir,
    output logic                           stick_present,
    output logic [3:0]                     quant_x,
    output logic [3:0]                     quant_y
);
    import williams_pkg::*;

    wire [7:0] lx = joy1_s[7:0];
    wire [7:0] ly = joy1_s[15:8];
    wire [7:0] rx = joy1_s[23:16];
    wire [7:0] ry = joy1_s[31:24];

    // an idle pad reports zero on the left stick
    assign stick_present = |joy1_s[15:0];

    assign stick_dir = {rx > STICK_HIGH, rx < STICK_LOW,
                        ry > STICK_HIGH, ry < STICK_LOW,
                        lx > STICK_HIGH, lx < STICK_LOW,
                        ly > STICK_HIGH, ly < STICK_LOW};

    assign quant_x = (lx < 8'd32)  ? 4'd0  :
                     (lx < 8'd64)  ? 4'd4  :
                     (lx < 8'd96)  ? 4'd6  :
                     (lx > 8'd224) ? 4'd8  :
                     (lx > 8'd192) ? 4'd9  :
                     (lx > 8'd160) ? 4'd11 : QUANT_CENTRE;

    // y axis runs the other way round
    assign quant_y = (ly < 8'd32)  ? 4'd8  :
                     (ly < 8'd64)  ? 4'd9  :
                     (ly < 8'd96)  ? 4'd11 :
                     (ly > 8'd224) ? 4'd0  :
                     (ly > 8'd192) ? 4'd4  :
                     (ly > 8'd160) ? 4'd6  : QUANT_CENTRE;

endmodule

`default_nettype wire

/* rtl/control_sync.sv */
// Controller synchroniser
// flop chain per bit for the pad key and stick words

`timescale 1ns/1ns
`default_nettype none

module control_sync #(
    parameter int SYNC_STAGES = 3
) (
    input  wire                             clk_74a,
    input  wire                             rst_n,
    input  wire  [williams_pkg::KEY_W-1:0]  cont1_key,
    input  wire  [williams_pkg::KEY_W-1:0]  cont2_key,
    input  wire  [williams_pkg::JOY_W-1:0]  cont1_joy,
    output logic [williams_pkg::KEY_W-1:0]  key1_s,
    output logic [williams_pkg::KEY_W-1:0]  key2_s,
    output logic [williams_pkg::JOY_W-1:0]  joy1_s
);
    import williams_pkg::*;

    localparam int W = 2 * KEY_W + JOY_W;

    logic [SYNC_STAGES-1:0][W-1:0] sync_q;

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            // stage 0 takes the raw words, each later stage the one before
            sync_q <= {sync_q[SYNC_STAGES-2:0], {cont1_joy, cont2_key, cont1_key}};
        end
    end

    assign {joy1_s, key2_s, key1_s} = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

/* rtl/bridge_config_regs.sv */
// Bridge configuration registers
// latches game selection and the settings flag from host writes

`timescale 1ns/1ns
`default_nettype none

module bridge_config_regs (
    input  wire                    clk_74a,
    input  wire                    rst_n,
    input  wire                    bridge_wr,
    input  wire  [31:0]            bridge_addr,
    input  wire  [31:0]            bridge_wr_data,
    output williams_pkg::game_id_t game_id,
    output logic                   original_controls
);
    import williams_pkg::*;

    // only bit 0 of the settings word has a meaning in this core
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            game_id           <= GAME_ROBOTRON;
            original_controls <= 1'b0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                ADDR_GAME_ID:  game_id <= game_id_t'(bridge_wr_data[2:0]);
                ADDR_SETTINGS: original_controls <= bridge_wr_data[0];
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/williams_pkg.sv */
// Williams I/O glue shared definitions
// game selection, bridge map, stick thresholds and video timing constants

`default_nettype none

package williams_pkg;

    // game selection as written by the host
    typedef enum logic [2:0] {
        GAME_ROBOTRON   = 3'd0,
        GAME_JOUST      = 3'd1,
        GAME_STARGATE   = 3'd2,
        GAME_BUBBLES    = 3'd3,
        GAME_SPLAT      = 3'd4,
        GAME_SINISTAR   = 3'd5,
        GAME_PLAYBALL   = 3'd6,
        GAME_ALIENARENA = 3'd7
    } game_id_t;

    // bridge register map
    localparam logic [31:0] ADDR_GAME_ID  = 32'h8000_0000;
    localparam logic [31:0] ADDR_SETTINGS = 32'h9000_0000;

    // analog stick direction thresholds on unsigned bytes
    localparam logic [7:0] STICK_HIGH = 8'd192;
    localparam logic [7:0] STICK_LOW  = 8'd64;

    // eight-way position of a centred stick
    localparam logic [3:0] QUANT_CENTRE = 4'd7;

    localparam int KEY_W = 16;
    localparam int JOY_W = 32;

    // hblank thresholds apply to the pixel count divided by two
    localparam int HBLANK_START = 336;
    localparam int HBLANK_END   = 40;
    localparam int VBLANK_START = 254;
    localparam int VBLANK_END   = 14;

    // dark green border for rotated games
    localparam logic [23:0] PORTRAIT_BG = {8'h00, 3'b001, 13'h0000};

endpackage

`default_nettype wire
